//--- flist.f
mm_pkg.sv
mm_regs_pkg.sv
mm_host_if.sv
mm_pe.sv
mm_systolic_array.sv
mm_operand_bank.sv
mm_skew_feeder.sv
mm_axil_slave.sv
mm_top.sv
mm_props.sv
tb_mm_top.sv

//--- Bender.yml
package:
  name: mm_systolic

sources:
  - mm_pkg.sv
  - mm_regs_pkg.sv
  - mm_host_if.sv
  - mm_pe.sv
  - mm_systolic_array.sv
  - mm_operand_bank.sv
  - mm_skew_feeder.sv
  - mm_axil_slave.sv
  - mm_top.sv
  - target: test
    files:
      - mm_props.sv
      - tb_mm_top.sv

//--- tb_mm_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mm_top;

  localparam int N          = mm_pkg::ARRAY_N;
  localparam int AW         = mm_regs_pkg::AXI_ADDR_W;
  localparam int DW         = mm_regs_pkg::AXI_DATA_W;
  localparam int CLK_PERIOD = 8;
  localparam int RUNS       = 10;
  localparam int RUN_CYCLES = 3 * N - 1;
  // operand writes, result reads and status polls take about 4 cycles each
  localparam int AXI_CYCLES = (2 * N * N + N * N + 2 * RUN_CYCLES) * 4;
  localparam int MARGIN     = 4;
  localparam int WATCHDOG_NS = RUNS * (RUN_CYCLES + AXI_CYCLES) * MARGIN * CLK_PERIOD;

  localparam logic [DW-1:0] BUSY_MASK = DW'(1) << mm_regs_pkg::STAT_BUSY;
  localparam logic [DW-1:0] DONE_MASK = DW'(1) << mm_regs_pkg::STAT_DONE;
  localparam logic [DW-1:0] FULL_MASK = DW'(1) << mm_regs_pkg::STAT_FULL;

  typedef int mat_t [N*N];

  logic          clk;
  logic          rst_n;
  logic          axi_awvalid;
  logic          axi_awready;
  logic [AW-1:0] axi_awaddr;
  logic          axi_wvalid;
  logic          axi_wready;
  logic [DW-1:0] axi_wdata;
  logic [DW/8-1:0] axi_wstrb;
  logic          axi_bvalid;
  logic          axi_bready;
  logic [1:0]    axi_bresp;
  logic          axi_arvalid;
  logic          axi_arready;
  logic [AW-1:0] axi_araddr;
  logic          axi_rvalid;
  logic          axi_rready;
  logic [DW-1:0] axi_rdata;
  logic [1:0]    axi_rresp;

  int            cmp_errors = 0;
  int            resp_errors = 0;
  // cycles the host holds back bready and rready
  int            resp_stall = 0;
  logic [DW-1:0] exp_q [$];
  logic [DW-1:0] got_q [$];
  int            idx_q [$];

  mm_top #(.N(N)) mm_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_awvalid (axi_awvalid),
    .o_awready (axi_awready),
    .i_awaddr  (axi_awaddr),
    .i_wvalid  (axi_wvalid),
    .o_wready  (axi_wready),
    .i_wdata   (axi_wdata),
    .i_wstrb   (axi_wstrb),
    .o_bvalid  (axi_bvalid),
    .i_bready  (axi_bready),
    .o_bresp   (axi_bresp),
    .i_arvalid (axi_arvalid),
    .o_arready (axi_arready),
    .i_araddr  (axi_araddr),
    .o_rvalid  (axi_rvalid),
    .i_rready  (axi_rready),
    .o_rdata   (axi_rdata),
    .o_rresp   (axi_rresp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // C = A*B with each element wrapped to 16 bits and sign-extended to the bus width
  function automatic logic [DW-1:0] ref_elem(input mat_t a, input mat_t b,
                                             input int i, input int j);
    int                              sum;
    logic signed [mm_pkg::ACC_W-1:0] wrapped;
    sum = 0;
    for (int k = 0; k < N; k++) begin
      sum += a[i * N + k] * b[k * N + j];
    end
    wrapped = sum[mm_pkg::ACC_W-1:0];
    return {{(DW - mm_pkg::ACC_W){wrapped[mm_pkg::ACC_W-1]}}, wrapped};
  endfunction

  task automatic check_resp(input string what, input logic [1:0] got, input logic [1:0] exp);
    assert (got == exp) else begin
      resp_errors++;
      $display("** Error @ %0t ns: %s response %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // entered and left 1 ns after a rising edge
  task automatic axi_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                           input logic [1:0] exp_resp);
    axi_awvalid = 1'b1;
    axi_awaddr  = addr;
    axi_wvalid  = 1'b1;
    axi_wdata   = data;
    axi_bready  = (resp_stall == 0);
    @(negedge clk);
    while (!axi_awready) @(negedge clk);
    @(posedge clk);
    #1;
    axi_awvalid = 1'b0;
    axi_wvalid  = 1'b0;
    @(negedge clk);
    while (!axi_bvalid) @(negedge clk);
    if (resp_stall > 0) begin
      // the same request again has to wait for the pending response
      @(posedge clk);
      #1;
      axi_awvalid = 1'b1;
      axi_wvalid  = 1'b1;
      repeat (resp_stall) begin
        @(negedge clk);
        assert (axi_bvalid && !axi_awready) else begin
          resp_errors++;
          $display("write 0x%02h: response dropped or new write taken while held at %0t ns",
                   addr, $time);
        end
      end
      @(posedge clk);
      #1;
      axi_awvalid = 1'b0;
      axi_wvalid  = 1'b0;
      axi_bready  = 1'b1;
      @(negedge clk);
    end
    check_resp($sformatf("write 0x%02h", addr), axi_bresp, exp_resp);
    @(posedge clk);
    #1;
  endtask

  task automatic axi_read(input logic [AW-1:0] addr, output logic [DW-1:0] data,
                          input logic [1:0] exp_resp);
    axi_arvalid = 1'b1;
    axi_araddr  = addr;
    axi_rready  = (resp_stall == 0);
    @(negedge clk);
    while (!axi_arready) @(negedge clk);
    @(posedge clk);
    #1;
    axi_arvalid = 1'b0;
    @(negedge clk);
    while (!axi_rvalid) @(negedge clk);
    data = axi_rdata;
    if (resp_stall > 0) begin
      repeat (resp_stall) begin
        @(negedge clk);
        assert (axi_rvalid && !axi_arready && axi_rdata == data) else begin
          resp_errors++;
          $display("read 0x%02h: response changed or new read allowed while held at %0t ns",
                   addr, $time);
        end
      end
      @(posedge clk);
      #1;
      axi_rready = 1'b1;
      @(negedge clk);
    end
    check_resp($sformatf("read 0x%02h", addr), axi_rresp, exp_resp);
    @(posedge clk);
    #1;
  endtask

  task automatic check_status(input logic [DW-1:0] exp);
    logic [DW-1:0] st;
    axi_read(mm_regs_pkg::REG_STATUS, st, mm_regs_pkg::RESP_OKAY);
    assert (st == exp) else begin
      resp_errors++;
      $display("** Error @ %0t ns: status 0x%0h, expected 0x%0h", $time, st, exp);
    end
  endtask

  task automatic random_mats(output mat_t a, output mat_t b);
    mm_pkg::elem_t v;
    for (int k = 0; k < N * N; k++) begin
      v = $urandom;
      a[k] = v;
      v = $urandom;
      b[k] = v;
    end
  endtask

  task automatic write_operands(input mat_t a, input mat_t b);
    for (int k = 0; k < N * N; k++) begin
      axi_write(mm_regs_pkg::OPND_BASE + AW'(4 * k), DW'(a[k]), mm_regs_pkg::RESP_OKAY);
    end
    for (int k = 0; k < N * N; k++) begin
      axi_write(mm_regs_pkg::OPND_BASE + AW'(4 * (N * N + k)), DW'(b[k]),
                mm_regs_pkg::RESP_OKAY);
    end
  endtask

  task automatic start_run();
    axi_write(mm_regs_pkg::REG_CTRL, DW'(1) << mm_regs_pkg::CTRL_START,
              mm_regs_pkg::RESP_OKAY);
  endtask

  task automatic wait_done();
    logic [DW-1:0] st;
    st = '0;
    while (!st[mm_regs_pkg::STAT_DONE]) begin
      axi_read(mm_regs_pkg::REG_STATUS, st, mm_regs_pkg::RESP_OKAY);
    end
  endtask

  // reads back all results and queues them for the compare process
  task automatic check_results(input mat_t a, input mat_t b);
    logic [DW-1:0] got;
    for (int k = 0; k < N * N; k++) begin
      axi_read(mm_regs_pkg::RES_BASE + AW'(4 * k), got, mm_regs_pkg::RESP_OKAY);
      exp_q.push_back(ref_elem(a, b, k / N, k % N));
      got_q.push_back(got);
      idx_q.push_back(k);
    end
  endtask

  task automatic run_and_check(input mat_t a, input mat_t b);
    write_operands(a, b);
    start_run();
    wait_done();
    check_results(a, b);
  endtask

  always @(negedge clk) begin : compare
    logic [DW-1:0] exp_v;
    logic [DW-1:0] got_v;
    int            idx_v;
    while (got_q.size() > 0) begin
      exp_v = exp_q.pop_front();
      got_v = got_q.pop_front();
      idx_v = idx_q.pop_front();
      assert (got_v == exp_v) else begin
        cmp_errors++;
        $display("** Error @ %0t ns: result %0d expected %0d, got %0d",
                 $time, idx_v, $signed(exp_v), $signed(got_v));
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

  initial begin : main
    mat_t          a;
    mat_t          b;
    logic [DW-1:0] data;
    int            prop_fails;
    void'($urandom(55550));
    clk         = 1'b0;
    rst_n       = 1'b0;
    axi_awvalid = 1'b0;
    axi_awaddr  = '0;
    axi_wvalid  = 1'b0;
    axi_wdata   = '0;
    axi_wstrb   = '1;
    axi_bready  = 1'b1;
    axi_arvalid = 1'b0;
    axi_araddr  = '0;
    axi_rready  = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // reset state and then full after every slot is written
    check_status('0);
    random_mats(a, b);
    write_operands(a, b);
    check_status(FULL_MASK);
    start_run();
    wait_done();
    check_results(a, b);
    for (int r = 1; r < 5; r++) begin
      random_mats(a, b);
      run_and_check(a, b);
    end
    check_status(DONE_MASK | FULL_MASK);

    // start with one slot missing is ignored
    axi_write(mm_regs_pkg::REG_CTRL, DW'(1) << mm_regs_pkg::CTRL_CLEAR,
              mm_regs_pkg::RESP_OKAY);
    for (int k = 0; k < 2 * N * N - 1; k++) begin
      axi_write(mm_regs_pkg::OPND_BASE + AW'(4 * k), '0, mm_regs_pkg::RESP_OKAY);
    end
    check_status(DONE_MASK);
    start_run();
    check_status(DONE_MASK);
    axi_write(mm_regs_pkg::OPND_BASE + AW'(4 * (2 * N * N - 1)), '0, mm_regs_pkg::RESP_OKAY);
    check_status(DONE_MASK | FULL_MASK);

    // operand write during a run is refused
    random_mats(a, b);
    write_operands(a, b);
    start_run();
    check_status(BUSY_MASK | FULL_MASK);
    axi_write(mm_regs_pkg::OPND_BASE, DW'(a[0] ^ 8'h55), mm_regs_pkg::RESP_SLVERR);
    wait_done();
    check_results(a, b);
    // bank still holds the old operands
    start_run();
    check_status(BUSY_MASK | FULL_MASK);
    wait_done();
    check_results(a, b);

    // illegal accesses
    axi_write(mm_regs_pkg::REG_STATUS, '0, mm_regs_pkg::RESP_SLVERR);
    axi_write(mm_regs_pkg::RES_BASE + AW'(4 * (N * N - 1)), '0, mm_regs_pkg::RESP_SLVERR);
    axi_read(8'h08, data, mm_regs_pkg::RESP_SLVERR);
    assert (data == '0) else begin
      resp_errors++;
      $display("** Error @ %0t ns: unmapped read data 0x%0h, expected 0", $time, data);
    end
    axi_read(8'hFC, data, mm_regs_pkg::RESP_SLVERR);

    // responses held back by the host while the array runs
    resp_stall = 2;
    random_mats(a, b);
    run_and_check(a, b);
    resp_stall = 0;

    // extreme operands make the sums wrap
    for (int k = 0; k < N * N; k++) begin
      a[k] = -128;
      b[k] = 127;
    end
    run_and_check(a, b);
    for (int k = 0; k < N * N; k++) begin
      b[k] = -128;
    end
    run_and_check(a, b);

    wait (got_q.size() == 0);
    #(CLK_PERIOD);
    prop_fails = mm_top_inst.u_props.fail_cnt;
    $display("summary: %0d result mismatches, %0d response errors, %0d assertion failures",
             cmp_errors, resp_errors, prop_fails);
    if (cmp_errors + resp_errors + prop_fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mm_props.sv
`timescale 1ns/1ps
`default_nettype none

module mm_props #(
  parameter int N = mm_pkg::ARRAY_N
) (
  input logic                                clk,
  input logic                                rst_n,
  input logic                                i_bvalid,
  input logic                                i_bready,
  input logic                                i_rvalid,
  input logic                                i_rready,
  input logic [mm_regs_pkg::AXI_DATA_W-1:0]  i_rdata,
  mm_host_if.monitor                         host
);

  localparam int RUN_LEN = 3 * N - 1;

  int fail_cnt = 0;

  bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_bvalid && !i_bready |=> i_bvalid)
  else begin
    fail_cnt++;
    $error("bvalid dropped before bready");
  end

  // read data stays put while the response waits
  rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata))
  else begin
    fail_cnt++;
    $error("rvalid or rdata changed before rready");
  end

  busy_done_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(host.busy && host.done))
  else begin
    fail_cnt++;
    $error("busy and done high together");
  end

  busy_len: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(host.busy) |-> host.busy [*RUN_LEN] ##1 !host.busy)
  else begin
    fail_cnt++;
    $error("busy length differs from 3N-1 cycles");
  end

endmodule

bind mm_top mm_props #(.N(N)) u_props (
  .clk      (clk),
  .rst_n    (rst_n),
  .i_bvalid (o_bvalid),
  .i_bready (i_bready),
  .i_rvalid (o_rvalid),
  .i_rready (i_rready),
  .i_rdata  (o_rdata),
  .host     (host.monitor)
);

`default_nettype wire

//--- mm_top.sv
`timescale 1ns/1ps
`default_nettype none

module mm_top #(
  parameter int N = mm_pkg::ARRAY_N
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                i_awvalid,
  output logic                                o_awready,
  input  logic [mm_regs_pkg::AXI_ADDR_W-1:0]  i_awaddr,
  input  logic                                i_wvalid,
  output logic                                o_wready,
  input  logic [mm_regs_pkg::AXI_DATA_W-1:0]  i_wdata,
  // strobes are ignored, every write is a full word
  input  logic [mm_regs_pkg::AXI_DATA_W/8-1:0] i_wstrb,
  output logic                                o_bvalid,
  input  logic                                i_bready,
  output logic [1:0]                          o_bresp,
  input  logic                                i_arvalid,
  output logic                                o_arready,
  input  logic [mm_regs_pkg::AXI_ADDR_W-1:0]  i_araddr,
  output logic                                o_rvalid,
  input  logic                                i_rready,
  output logic [mm_regs_pkg::AXI_DATA_W-1:0]  o_rdata,
  output logic [1:0]                          o_rresp
);

  mm_host_if #(.N(N)) host ();

  mm_pkg::elem_t [N-1:0][N-1:0] a_mat;
  mm_pkg::elem_t [N-1:0][N-1:0] b_mat;
  mm_pkg::elem_t [N-1:0]        row_a;
  mm_pkg::elem_t [N-1:0]        col_b;
  logic                         clear_acc;
  mm_pkg::acc_t  [N-1:0][N-1:0] results;

  mm_axil_slave #(.N(N)) u_slave (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_awaddr  (i_awaddr),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_wdata   (i_wdata),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .i_araddr  (i_araddr),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .host      (host.slave),
    .i_results (results)
  );

  mm_operand_bank #(.N(N)) u_bank (
    .clk     (clk),
    .rst_n   (rst_n),
    .host    (host.bank),
    .o_a_mat (a_mat),
    .o_b_mat (b_mat)
  );

  mm_skew_feeder #(.N(N)) u_feeder (
    .clk         (clk),
    .rst_n       (rst_n),
    .host        (host.feeder),
    .i_a_mat     (a_mat),
    .i_b_mat     (b_mat),
    .o_row_a     (row_a),
    .o_col_b     (col_b),
    .o_clear_acc (clear_acc)
  );

  mm_systolic_array #(.N(N)) u_array (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_clear_acc (clear_acc),
    .i_row_a     (row_a),
    .i_col_b     (col_b),
    .o_results   (results)
  );

endmodule

`default_nettype wire

//--- mm_axil_slave.sv
`timescale 1ns/1ps
`default_nettype none

module mm_axil_slave #(
  parameter int N = mm_pkg::ARRAY_N
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                i_awvalid,
  output logic                                o_awready,
  input  logic [mm_regs_pkg::AXI_ADDR_W-1:0]  i_awaddr,
  input  logic                                i_wvalid,
  output logic                                o_wready,
  input  logic [mm_regs_pkg::AXI_DATA_W-1:0]  i_wdata,
  output logic                                o_bvalid,
  input  logic                                i_bready,
  output logic [1:0]                          o_bresp,
  input  logic                                i_arvalid,
  output logic                                o_arready,
  input  logic [mm_regs_pkg::AXI_ADDR_W-1:0]  i_araddr,
  output logic                                o_rvalid,
  input  logic                                i_rready,
  output logic [mm_regs_pkg::AXI_DATA_W-1:0]  o_rdata,
  output logic [1:0]                          o_rresp,
  mm_host_if.slave                            host,
  input  mm_pkg::acc_t [N-1:0][N-1:0]         i_results
);

  localparam int SLOTS   = 2 * N * N;
  localparam int RESULTS = N * N;
  localparam int IDX_W   = $clog2(SLOTS);

  logic                               wr_go;
  logic                               wr_is_ctrl;
  logic                               wr_is_opnd;
  logic [mm_regs_pkg::AXI_ADDR_W-1:0] wr_off;
  logic                               bvalid_q;
  mm_regs_pkg::axi_resp_t             bresp_q;
  logic                               start_q;
  logic                               clear_q;
  logic                               we_q;
  logic [IDX_W-1:0]                   idx_q;
  mm_pkg::elem_t                      data_q;

  logic                               ar_go;
  logic                               arready_q;
  logic                               rvalid_q;
  mm_regs_pkg::axi_resp_t             rresp_q;
  logic [mm_regs_pkg::AXI_DATA_W-1:0] rdata_q;
  logic [mm_regs_pkg::AXI_ADDR_W-1:0] rd_off;
  logic [mm_regs_pkg::AXI_DATA_W-1:0] rd_data;
  mm_regs_pkg::axi_resp_t             rd_resp;

  // address and data are taken together, one write in flight
  assign wr_go     = i_awvalid && i_wvalid && !bvalid_q;
  assign o_awready = wr_go;
  assign o_wready  = wr_go;

  // operand and result windows overlap at 0x80..0x87, so writes decode operands
  // and reads decode results
  assign wr_off     = i_awaddr - mm_regs_pkg::OPND_BASE;
  assign wr_is_ctrl = (i_awaddr == mm_regs_pkg::REG_CTRL);
  assign wr_is_opnd = (i_awaddr >= mm_regs_pkg::OPND_BASE) && (wr_off < 4 * SLOTS) &&
                      (i_awaddr[1:0] == 2'b00);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid_q <= 1'b0;
      bresp_q  <= mm_regs_pkg::RESP_OKAY;
      start_q  <= 1'b0;
      clear_q  <= 1'b0;
      we_q     <= 1'b0;
    end else begin
      start_q <= 1'b0;
      clear_q <= 1'b0;
      we_q    <= 1'b0;
      if (bvalid_q && i_bready) begin
        bvalid_q <= 1'b0;
      end
      if (wr_go) begin
        bvalid_q <= 1'b1;
        bresp_q  <= mm_regs_pkg::RESP_OKAY;
        if (wr_is_ctrl) begin
          start_q <= i_wdata[mm_regs_pkg::CTRL_START];
          clear_q <= i_wdata[mm_regs_pkg::CTRL_CLEAR];
        end else if (wr_is_opnd && !host.busy) begin
          we_q <= 1'b1;
        end else begin
          // busy operand write, status, results or unmapped
          bresp_q <= mm_regs_pkg::RESP_SLVERR;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_go) begin
      idx_q  <= IDX_W'(wr_off >> 2);
      data_q <= i_wdata[mm_pkg::ELEM_W-1:0];
    end
  end

  assign o_bvalid         = bvalid_q;
  assign o_bresp          = bresp_q;
  assign host.opnd_we     = we_q;
  assign host.opnd_idx    = idx_q;
  assign host.opnd_data   = data_q;
  assign host.start_pulse = start_q;
  assign host.clear_pulse = clear_q;

  // read decode
  assign rd_off = i_araddr - mm_regs_pkg::RES_BASE;

  always_comb begin
    rd_data = '0;
    rd_resp = mm_regs_pkg::RESP_SLVERR;
    if (i_araddr == mm_regs_pkg::REG_CTRL) begin
      rd_resp = mm_regs_pkg::RESP_OKAY;
    end else if (i_araddr == mm_regs_pkg::REG_STATUS) begin
      rd_resp = mm_regs_pkg::RESP_OKAY;
      rd_data[mm_regs_pkg::STAT_BUSY] = host.busy;
      rd_data[mm_regs_pkg::STAT_DONE] = host.done;
      rd_data[mm_regs_pkg::STAT_FULL] = host.full;
    end else if (i_araddr >= mm_regs_pkg::RES_BASE && i_araddr[1:0] == 2'b00) begin
      for (int k = 0; k < RESULTS; k++) begin
        if (rd_off == 4 * k) begin
          rd_resp = mm_regs_pkg::RESP_OKAY;
          // sign-extended
          rd_data = mm_regs_pkg::AXI_DATA_W'(i_results[k / N][k % N]);
        end
      end
    end
  end

  assign ar_go     = i_arvalid && arready_q;
  assign o_arready = arready_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      rresp_q   <= mm_regs_pkg::RESP_OKAY;
    end else if (ar_go) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b1;
      rresp_q   <= rd_resp;
    end else begin
      if (rvalid_q && i_rready) begin
        rvalid_q <= 1'b0;
      end
      // ready again once the response has gone
      arready_q <= !rvalid_q || i_rready;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_go) begin
      rdata_q <= rd_data;
    end
  end

  assign o_rvalid = rvalid_q;
  assign o_rdata  = rdata_q;
  assign o_rresp  = rresp_q;

endmodule

`default_nettype wire

//--- mm_skew_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module mm_skew_feeder #(
  parameter int N = mm_pkg::ARRAY_N
) (
  input  logic                          clk,
  input  logic                          rst_n,
  mm_host_if.feeder                     host,
  input  mm_pkg::elem_t [N-1:0][N-1:0]  i_a_mat,
  input  mm_pkg::elem_t [N-1:0][N-1:0]  i_b_mat,
  output mm_pkg::elem_t [N-1:0]         o_row_a,
  output mm_pkg::elem_t [N-1:0]         o_col_b,
  output logic                          o_clear_acc
);

  // last feed cycle, busy spans 0..LAST
  localparam int LAST  = 3 * N - 2;
  localparam int CNT_W = $clog2(LAST + 1);

  mm_pkg::seq_state_t    state_q;
  logic [CNT_W-1:0]      cnt_q;
  logic                  accept;
  mm_pkg::elem_t [N-1:0] sel_a;
  mm_pkg::elem_t [N-1:0] sel_b;

  assign accept      = host.start_pulse && host.full && (state_q != mm_pkg::SEQ_RUN);
  assign o_clear_acc = accept;
  assign host.busy   = (state_q == mm_pkg::SEQ_RUN);
  assign host.done   = (state_q == mm_pkg::SEQ_DONE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mm_pkg::SEQ_IDLE;
      cnt_q   <= '0;
    end else if (accept) begin
      state_q <= mm_pkg::SEQ_RUN;
      cnt_q   <= '0;
    end else if (state_q == mm_pkg::SEQ_RUN) begin
      if (cnt_q == CNT_W'(LAST)) begin
        state_q <= mm_pkg::SEQ_DONE;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // column k of A and row k of B in feed cycle k, zeros elsewhere
  always_comb begin
    sel_a = '0;
    sel_b = '0;
    if (state_q == mm_pkg::SEQ_RUN) begin
      for (int k = 0; k < N; k++) begin
        if (cnt_q == k) begin
          for (int i = 0; i < N; i++) begin
            sel_a[i] = i_a_mat[i][k];
            sel_b[i] = i_b_mat[k][i];
          end
        end
      end
    end
  end

  // lane i holds row i of A and column i of B, both delayed by i cycles
  for (genvar i = 0; i < N; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign o_row_a[i] = sel_a[i];
      assign o_col_b[i] = sel_b[i];
    end else begin : g_skew
      logic [2*mm_pkg::ELEM_W-1:0] pipe_q [i];

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          for (int s = 0; s < i; s++) begin
            pipe_q[s] <= '0;
          end
        end else begin
          pipe_q[0] <= {sel_a[i], sel_b[i]};
          for (int s = 1; s < i; s++) begin
            pipe_q[s] <= pipe_q[s-1];
          end
        end
      end

      assign o_row_a[i] = pipe_q[i-1][2*mm_pkg::ELEM_W-1:mm_pkg::ELEM_W];
      assign o_col_b[i] = pipe_q[i-1][mm_pkg::ELEM_W-1:0];
    end
  end

endmodule

`default_nettype wire

//--- mm_operand_bank.sv
`timescale 1ns/1ps
`default_nettype none

module mm_operand_bank #(
  parameter int N = mm_pkg::ARRAY_N
) (
  input  logic                          clk,
  input  logic                          rst_n,
  mm_host_if.bank                       host,
  output mm_pkg::elem_t [N-1:0][N-1:0]  o_a_mat,
  output mm_pkg::elem_t [N-1:0][N-1:0]  o_b_mat
);

  localparam int SLOTS = 2 * N * N;

  mm_pkg::elem_t    slot_q [SLOTS];
  logic [SLOTS-1:0] mask_q;

  always_ff @(posedge clk) begin
    if (host.opnd_we) begin
      slot_q[host.opnd_idx] <= host.opnd_data;
    end
  end

  // one bit per written slot, clear leaves the data alone
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mask_q <= '0;
    end else if (host.clear_pulse) begin
      mask_q <= '0;
    end else if (host.opnd_we) begin
      mask_q[host.opnd_idx] <= 1'b1;
    end
  end

  assign host.full = &mask_q;

  // A first, then B, both row-major
  always_comb begin
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        o_a_mat[r][c] = slot_q[r * N + c];
        o_b_mat[r][c] = slot_q[N * N + r * N + c];
      end
    end
  end

endmodule

`default_nettype wire

//--- mm_systolic_array.sv
`timescale 1ns/1ps
`default_nettype none

module mm_systolic_array #(
  parameter int N = mm_pkg::ARRAY_N
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          i_clear_acc,
  input  mm_pkg::elem_t [N-1:0]         i_row_a,
  input  mm_pkg::elem_t [N-1:0]         i_col_b,
  output mm_pkg::acc_t  [N-1:0][N-1:0]  o_results
);

  // A moves right along a row, B moves down a column
  mm_pkg::elem_t a_link [N][N+1];
  mm_pkg::elem_t b_link [N+1][N];

  for (genvar i = 0; i < N; i++) begin : g_edge
    assign a_link[i][0] = i_row_a[i];
    assign b_link[0][i] = i_col_b[i];
  end

  for (genvar i = 0; i < N; i++) begin : g_row
    for (genvar j = 0; j < N; j++) begin : g_col
      mm_pe u_pe (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_clear_acc (i_clear_acc),
        .i_a         (a_link[i][j]),
        .i_b         (b_link[i][j]),
        .o_a         (a_link[i][j+1]),
        .o_b         (b_link[i+1][j]),
        .o_acc       (o_results[i][j])
      );
    end
  end

endmodule

`default_nettype wire

//--- mm_pe.sv
`timescale 1ns/1ps
`default_nettype none

module mm_pe (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          i_clear_acc,
  input  mm_pkg::elem_t i_a,
  input  mm_pkg::elem_t i_b,
  output mm_pkg::elem_t o_a,
  output mm_pkg::elem_t o_b,
  output mm_pkg::acc_t  o_acc
);

  mm_pkg::elem_t a_q;
  mm_pkg::elem_t b_q;
  mm_pkg::acc_t  acc_q;
  mm_pkg::acc_t  prod;

  // signed product, low 16 bits
  assign prod = i_a * i_b;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q   <= '0;
      b_q   <= '0;
      acc_q <= '0;
    end else begin
      a_q <= i_a;
      b_q <= i_b;
      if (i_clear_acc) begin
        acc_q <= '0;
      end else begin
        // wraps in two's complement
        acc_q <= acc_q + prod;
      end
    end
  end

  assign o_a   = a_q;
  assign o_b   = b_q;
  assign o_acc = acc_q;

endmodule

`default_nettype wire

//--- mm_host_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mm_host_if #(
  parameter int N = mm_pkg::ARRAY_N
);

  localparam int IDX_W = $clog2(2 * N * N);

  // operand slot write
  logic              opnd_we;
  logic [IDX_W-1:0]  opnd_idx;
  mm_pkg::elem_t     opnd_data;

  // control pulses
  logic              start_pulse;
  logic              clear_pulse;

  // status
  logic              full;
  logic              busy;
  logic              done;

  modport slave (
    output opnd_we, opnd_idx, opnd_data, start_pulse, clear_pulse,
    input  full, busy, done
  );

  modport bank (
    input  opnd_we, opnd_idx, opnd_data, clear_pulse,
    output full
  );

  modport feeder (
    input  start_pulse, full,
    output busy, done
  );

  // observation only
  modport monitor (
    input opnd_we, opnd_idx, opnd_data, start_pulse, clear_pulse, full, busy, done
  );

endinterface

`default_nettype wire

//--- mm_regs_pkg.sv
`default_nettype none

package mm_regs_pkg;

  localparam int AXI_ADDR_W = 8;
  localparam int AXI_DATA_W = 32;

  // register map
  localparam logic [AXI_ADDR_W-1:0] REG_CTRL   = 8'h00;
  localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 8'h04;
  localparam logic [AXI_ADDR_W-1:0] OPND_BASE  = 8'h40;
  localparam logic [AXI_ADDR_W-1:0] RES_BASE   = 8'h80;

  // control bits, write-only
  localparam int CTRL_START = 0;
  localparam int CTRL_CLEAR = 1;

  // status bits
  localparam int STAT_BUSY = 0;
  localparam int STAT_DONE = 1;
  localparam int STAT_FULL = 2;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_t;

endpackage

`default_nettype wire

//--- mm_pkg.sv
`default_nettype none

package mm_pkg;

  // array geometry
  localparam int ARRAY_N = 3;

  // operand and accumulator widths
  localparam int ELEM_W = 8;
  localparam int ACC_W  = 16;

  typedef logic signed [ELEM_W-1:0] elem_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  // run sequencer
  typedef enum logic [1:0] {
    SEQ_IDLE = 2'd0,
    SEQ_RUN  = 2'd1,
    SEQ_DONE = 2'd2
  } seq_state_t;

endpackage

`default_nettype wire
